/* dv/exec_tb.sv */
module exec_tb;
    import exec_pkg::*;

    // 60 alu, 14 flow, 3 memory and csr, 3 hazard, 1 trap, 4 back-pressure
    localparam int request_total = 85;
    localparam int cycle_limit   = 64 * request_total + 16;

    logic         clock;
    logic         reset;
    exec_req_t    exec_req;
    logic         req_valid;
    logic         req_ready;
    exec_result_t result;
    logic         result_valid;
    logic         result_ready;
    logic         jump_valid;
    logic [31:0]  jump_pc;
    logic         load_done;
    logic [4:0]   load_done_rd;

    integer seed;
    int     cycle_count;
    int     error_count;
    int     check_count;
    int     test_count;
    int     failed_tests;

    exec_top #(
        .REG_COUNT (32)
    ) u_exec_top (
        .clock        (clock),
        .reset        (reset),
        .exec_req     (exec_req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .result       (result),
        .result_valid (result_valid),
        .result_ready (result_ready),
        .jump_valid   (jump_valid),
        .jump_pc      (jump_pc),
        .load_done    (load_done),
        .load_done_rd (load_done_rd)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------

    function automatic logic [31:0] alu_model(alu_fn_t f, logic [31:0] a, logic [31:0] b);
        case (f)
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $unsigned($signed(a) >>> b[4:0]);
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] first_a(exec_req_t r);
        case (r.op.src_sel)
            src_imm_zero:            return r.imm;
            src_pc_imm, src_pc_four: return r.pc;
            default:                 return r.rs1_value;
        endcase
    endfunction

    function automatic logic [31:0] first_b(exec_req_t r);
        case (r.op.src_sel)
            src_rs1_rs2:             return r.rs2_value;
            src_rs1_imm, src_pc_imm: return r.imm;
            src_pc_four:             return 32'd4;
            src_rs1_csr:             return r.csr_value;
            default:                 return 32'd0;
        endcase
    endfunction

    function automatic exec_result_t expect_result(exec_req_t r);
        exec_result_t e;
        logic [31:0]  value;
        value        = alu_model(r.op.alu_fn, first_a(r), first_b(r));
        e            = '0;
        e.gpr_write  = r.op.gpr_write & ~r.trap;
        e.rd         = r.rd;
        e.rd_value   = r.op.csr_write ? r.csr_value : value;
        // a trap saves its pc in mepc
        e.csr_write  = r.op.csr_write | r.trap;
        e.csr_addr   = r.trap ? csr_mepc : r.csr_addr;
        e.csr_value  = r.trap ? r.pc : value;
        e.mem_valid  = (r.op.mem_load | r.op.mem_store) & ~r.trap;
        e.mem_write  = r.op.mem_store;
        e.mem_addr   = value;
        e.mem_wdata  = r.rs2_value;
        e.mem_size   = r.op.mem_size;
        e.mem_signed = r.op.mem_signed;
        e.pc         = r.pc;
        e.trap       = r.trap;
        e.trap_cause = r.trap_cause;
        return e;
    endfunction

    function automatic logic expect_jump(exec_req_t r);
        logic [31:0] a;
        logic [31:0] b;
        a = first_a(r);
        b = first_b(r);
        if (r.trap) begin
            return 1'b0;
        end
        case (r.op.flow)
            flow_jal, flow_jalr: return 1'b1;
            flow_branch: begin
                case (r.op.branch_cond)
                    cond_eq:  return a == b;
                    cond_ne:  return a != b;
                    cond_lt:  return $signed(a) < $signed(b);
                    cond_ge:  return $signed(a) >= $signed(b);
                    cond_ltu: return a < b;
                    cond_geu: return a >= b;
                    default:  return 1'b0;
                endcase
            end
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] expect_target(exec_req_t r);
        logic [31:0] sum;
        if (r.op.flow == flow_jalr) begin
            sum = r.rs1_value + r.imm;
            return {sum[31:1], 1'b0};
        end
        return r.pc + r.imm;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------

    task automatic compare_field(string field, logic [31:0] got, logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s is %h, expected %h", $time, field, got, expected);
        end
    endtask

    task automatic check_result(exec_result_t got, exec_result_t exp);
        compare_field("gpr_write", 32'(got.gpr_write), 32'(exp.gpr_write));
        if (exp.gpr_write) begin
            compare_field("rd", 32'(got.rd), 32'(exp.rd));
            compare_field("rd_value", got.rd_value, exp.rd_value);
        end
        compare_field("csr_write", 32'(got.csr_write), 32'(exp.csr_write));
        if (exp.csr_write) begin
            compare_field("csr_addr", 32'(got.csr_addr), 32'(exp.csr_addr));
            compare_field("csr_value", got.csr_value, exp.csr_value);
        end
        compare_field("mem_valid", 32'(got.mem_valid), 32'(exp.mem_valid));
        if (exp.mem_valid) begin
            compare_field("mem_write", 32'(got.mem_write), 32'(exp.mem_write));
            compare_field("mem_addr", got.mem_addr, exp.mem_addr);
            compare_field("mem_wdata", got.mem_wdata, exp.mem_wdata);
            compare_field("mem_size", 32'(got.mem_size), 32'(exp.mem_size));
            compare_field("mem_signed", 32'(got.mem_signed), 32'(exp.mem_signed));
        end
        compare_field("pc", got.pc, exp.pc);
        compare_field("trap", 32'(got.trap), 32'(exp.trap));
        if (exp.trap) begin
            compare_field("trap_cause", 32'(got.trap_cause), 32'(exp.trap_cause));
        end
    endtask

    task automatic check_jump(logic got_valid, logic [31:0] got_pc, logic exp_valid,
                              logic [31:0] exp_pc);
        compare_field("jump_valid", 32'(got_valid), 32'(exp_valid));
        if (exp_valid) begin
            compare_field("jump_pc", got_pc, exp_pc);
        end
    endtask

    // result must not move, pulse again or let a request in
    task automatic check_held(exec_result_t first);
        check_count++;
        if (!result_valid || result !== first || jump_valid || req_ready) begin
            error_count++;
            $display("Mismatch at %0t: waiting result changed, jump repeated or stage was ready",
                     $time);
        end
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------

    task automatic random_request(output exec_req_t r);
        r           = '0;
        r.rd        = 5'($random(seed));
        r.rs1       = 5'($random(seed));
        r.rs2       = 5'($random(seed));
        r.csr_addr  = 12'($random(seed));
        r.pc        = $random(seed) & 32'hffff_fffc;
        r.imm       = $random(seed);
        r.rs1_value = $random(seed);
        r.rs2_value = $random(seed);
        r.csr_value = $random(seed);
    endtask

    task automatic drive_request(exec_req_t r);
        @(posedge clock);
        exec_req  <= r;
        req_valid <= 1'b1;
    endtask

    // returns right after the accepting edge
    task automatic wait_accept(output int stalls);
        stalls = 0;
        @(negedge clock);
        while (!req_ready) begin
            stalls++;
            @(negedge clock);
        end
        @(posedge clock);
        req_valid <= 1'b0;
    endtask

    task automatic collect_result(exec_req_t r, int hold);
        exec_result_t expected;
        exec_result_t first;
        logic         taken;
        logic [31:0]  target;
        expected = expect_result(r);
        taken    = expect_jump(r);
        target   = expect_target(r);
        if (hold > 0) begin
            result_ready <= 1'b0;
        end
        @(negedge clock);
        if (result_valid || jump_valid) begin
            error_count++;
            $display("Result or jump showed up in the acceptance cycle at %0t", $time);
        end
        @(negedge clock);
        if (!result_valid) begin
            error_count++;
            $display("Result was missing one cycle after acceptance at %0t", $time);
            while (!result_valid) begin
                @(negedge clock);
            end
        end
        check_jump(jump_valid, jump_pc, taken, target);
        check_result(result, expected);
        first = result;
        for (int i = 0; i < hold; i++) begin
            @(negedge clock);
            check_held(first);
        end
        if (hold > 0) begin
            @(posedge clock);
            result_ready <= 1'b1;
            @(posedge clock);
        end
        @(negedge clock);
        if (result_valid || jump_valid) begin
            error_count++;
            $display("Result did not leave or jump repeated at %0t", $time);
        end
    endtask

    task automatic run_request(exec_req_t r, int hold, output int stalls);
        drive_request(r);
        wait_accept(stalls);
        collect_result(r, hold);
    endtask

    task automatic complete_load(logic [4:0] rd);
        @(posedge clock);
        load_done    <= 1'b1;
        load_done_rd <= rd;
        @(posedge clock);
        load_done    <= 1'b0;
    endtask

    task automatic report_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------

    task automatic test_alu_ops();
        alu_fn_t   fns [10];
        src_sel_t  srcs [6];
        exec_req_t r;
        int        stalls;
        int        errors_before;
        fns  = '{alu_add, alu_sub, alu_and, alu_or, alu_xor,
                 alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu};
        srcs = '{src_imm_zero, src_rs1_rs2, src_rs1_imm, src_pc_imm, src_pc_four, src_rs1_csr};
        errors_before = error_count;
        foreach (fns[f]) begin
            foreach (srcs[s]) begin
                random_request(r);
                r.op.alu_fn    = fns[f];
                r.op.src_sel   = srcs[s];
                r.op.gpr_write = 1'b1;
                run_request(r, 0, stalls);
            end
        end
        report_test("alu_ops", errors_before);
    endtask

    task automatic test_control_flow();
        branch_cond_t conds [6];
        exec_req_t    r;
        int           stalls;
        int           errors_before;
        conds = '{cond_eq, cond_ne, cond_lt, cond_ge, cond_ltu, cond_geu};
        errors_before = error_count;
        foreach (conds[c]) begin
            for (int want = 0; want < 2; want++) begin
                random_request(r);
                r.op.alu_fn      = alu_sub;
                r.op.src_sel     = src_rs1_rs2;
                r.op.flow        = flow_branch;
                r.op.branch_cond = conds[c];
                // redraw operands until the outcome is the wanted one
                for (int tries = 0; tries < 64 && expect_jump(r) != want[0]; tries++) begin
                    r.rs1_value = $random(seed);
                    if ($random(seed) & 1) begin
                        r.rs2_value = r.rs1_value;
                    end else begin
                        r.rs2_value = $random(seed);
                    end
                end
                run_request(r, 0, stalls);
            end
        end
        random_request(r);
        r.op.src_sel   = src_pc_four;
        r.op.flow      = flow_jal;
        r.op.gpr_write = 1'b1;
        run_request(r, 0, stalls);
        r.op.flow = flow_jalr;
        r.imm[0]  = 1'b1;
        run_request(r, 0, stalls);
        report_test("control_flow", errors_before);
    endtask

    task automatic test_memory_csr();
        exec_req_t r;
        int        stalls;
        int        errors_before;
        errors_before = error_count;
        random_request(r);
        r.rd            = 5'd9;
        r.op.src_sel    = src_rs1_imm;
        r.op.mem_load   = 1'b1;
        r.op.mem_size   = size_half;
        r.op.mem_signed = 1'b1;
        r.op.gpr_write  = 1'b1;
        run_request(r, 0, stalls);
        complete_load(5'd9);
        random_request(r);
        r.op.src_sel   = src_rs1_imm;
        r.op.mem_store = 1'b1;
        r.op.mem_size  = size_byte;
        run_request(r, 0, stalls);
        // set-bits style csr update
        random_request(r);
        r.op.alu_fn    = alu_or;
        r.op.src_sel   = src_rs1_csr;
        r.op.gpr_write = 1'b1;
        r.op.csr_write = 1'b1;
        run_request(r, 0, stalls);
        report_test("memory_csr", errors_before);
    endtask

    task automatic test_load_hazard();
        exec_req_t r;
        int        stalls;
        int        errors_before;
        errors_before = error_count;
        random_request(r);
        r.rd           = 5'd5;
        r.op.src_sel   = src_rs1_imm;
        r.op.mem_load  = 1'b1;
        r.op.mem_size  = size_word;
        r.op.gpr_write = 1'b1;
        run_request(r, 0, stalls);
        random_request(r);
        r.rd           = 5'd7;
        r.rs1          = 5'd6;
        r.rs2          = 5'd8;
        r.op.src_sel   = src_rs1_rs2;
        r.op.gpr_write = 1'b1;
        run_request(r, 0, stalls);
        if (stalls != 0) begin
            error_count++;
            $display("Request on free registers stalled %0d cycles at %0t", stalls, $time);
        end
        r.rd  = 5'd10;
        r.rs1 = 5'd5;
        r.rs2 = 5'd11;
        drive_request(r);
        repeat (4) begin
            @(negedge clock);
            if (req_ready) begin
                error_count++;
                $display("Stage was ready while x5 waits on a load at %0t", $time);
            end
        end
        complete_load(5'd5);
        wait_accept(stalls);
        collect_result(r, 0);
        report_test("load_hazard", errors_before);
    endtask

    task automatic test_trap();
        exec_req_t r;
        int        stalls;
        int        errors_before;
        errors_before = error_count;
        random_request(r);
        r.op.src_sel    = src_pc_four;
        r.op.flow       = flow_jal;
        r.op.mem_store  = 1'b1;
        r.op.gpr_write  = 1'b1;
        r.trap          = 1'b1;
        r.trap_cause    = 4'd2;
        run_request(r, 0, stalls);
        report_test("trap", errors_before);
    endtask

    task automatic test_back_pressure();
        flow_t     flows [4];
        exec_req_t r;
        int        stalls;
        int        hold;
        int        errors_before;
        flows = '{flow_jal, flow_none, flow_jalr, flow_jal};
        errors_before = error_count;
        foreach (flows[i]) begin
            random_request(r);
            r.op.src_sel   = src_pc_four;
            r.op.flow      = flows[i];
            r.op.gpr_write = 1'b1;
            hold = 1 + ($random(seed) & 7);
            run_request(r, hold, stalls);
        end
        report_test("back_pressure", errors_before);
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------

    initial begin
        seed         = 32'h8dfb;
        cycle_count  = 0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        clock        = 1'b0;
        reset        = 1'b1;
        exec_req     = '0;
        req_valid    = 1'b0;
        result_ready = 1'b1;
        load_done    = 1'b0;
        load_done_rd = 5'd0;
        repeat (16) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (!req_ready || result_valid || jump_valid) begin
            error_count++;
            $display("Outputs were not idle after reset at %0t", $time);
        end
        test_alu_ops();
        test_control_flow();
        test_memory_csr();
        test_load_hazard();
        test_trap();
        test_back_pressure();
        @(posedge clock);
        $display("tests %0d, failing %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module exec_tb \
    -f rv_exec.f \
    -o Vexec_tb

output=$(./obj_dir/Vexec_tb || true)
echo "$output"

if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* rv_exec.f */
source/exec_pkg.sv
source/alu.sv
source/load_scoreboard.sv
source/exec_unit.sv
source/exec_top.sv
dv/exec_tb.sv

/* source/alu.sv */
module alu (
    input  logic [31:0]       operand_a,
    input  logic [31:0]       operand_b,
    input  exec_pkg::alu_fn_t fn,
    output logic [31:0]       alu_result,
    output logic              alu_equal,
    output logic              alu_less_signed,
    output logic              alu_less_unsigned
);
    import exec_pkg::*;

    logic [4:0]  shamt;
    logic [31:0] sum;
    logic [31:0] difference;

    assign shamt      = operand_b[4:0];
    assign sum        = operand_a + operand_b;
    assign difference = operand_a - operand_b;

    // ----------------------------------------
    // compare flags
    // ----------------------------------------

    // always valid, whatever fn selects
    assign alu_equal         = (operand_a == operand_b);
    assign alu_less_signed   = ($signed(operand_a) < $signed(operand_b));
    assign alu_less_unsigned = (operand_a < operand_b);

    // ----------------------------------------
    // function select
    // ----------------------------------------

    always_comb begin
        case (fn)
            alu_add: begin
                alu_result = sum;
            end
            alu_sub: begin
                alu_result = difference;
            end
            alu_and: begin
                alu_result = operand_a & operand_b;
            end
            alu_or: begin
                alu_result = operand_a | operand_b;
            end
            alu_xor: begin
                alu_result = operand_a ^ operand_b;
            end
            alu_sll: begin
                alu_result = operand_a << shamt;
            end
            alu_srl: begin
                alu_result = operand_a >> shamt;
            end
            alu_sra: begin
                // arithmetic shift keeps the sign bit
                alu_result = $signed(operand_a) >>> shamt;
            end
            alu_slt: begin
                alu_result = {31'd0, alu_less_signed};
            end
            alu_sltu: begin
                alu_result = {31'd0, alu_less_unsigned};
            end
            default: begin
                alu_result = 32'd0;
            end
        endcase
    end

endmodule

/* source/exec_pkg.sv */
package exec_pkg;

    // ----------------------------------------
    // operation encodings
    // ----------------------------------------

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_fn_t;

    // first-pass operand pairs, a then b
    typedef enum logic [2:0] {
        src_imm_zero = 3'd0,
        src_rs1_rs2  = 3'd1,
        src_rs1_imm  = 3'd2,
        src_pc_imm   = 3'd3,
        src_pc_four  = 3'd4,
        src_rs1_csr  = 3'd5
    } src_sel_t;

    typedef enum logic [1:0] {
        flow_none   = 2'd0,
        flow_branch = 2'd1,
        flow_jal    = 2'd2,
        flow_jalr   = 2'd3
    } flow_t;

    typedef enum logic [2:0] {
        cond_eq  = 3'd0,
        cond_ne  = 3'd1,
        cond_lt  = 3'd2,
        cond_ge  = 3'd3,
        cond_ltu = 3'd4,
        cond_geu = 3'd5
    } branch_cond_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_t;

    localparam logic [11:0] csr_mepc = 12'h341;

    // ----------------------------------------
    // request and result packets
    // ----------------------------------------

    typedef struct packed {
        alu_fn_t      alu_fn;
        src_sel_t     src_sel;
        flow_t        flow;
        branch_cond_t branch_cond;
        logic         mem_load;
        logic         mem_store;
        mem_size_t    mem_size;
        logic         mem_signed;
        logic         gpr_write;
        logic         csr_write;
    } exec_op_t;

    typedef struct packed {
        exec_op_t    op;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] csr_addr;
        logic [31:0] pc;
        logic [31:0] imm;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
        logic [31:0] csr_value;
        logic        trap;
        logic [3:0]  trap_cause;
    } exec_req_t;

    typedef struct packed {
        logic        gpr_write;
        logic [4:0]  rd;
        logic [31:0] rd_value;
        logic        csr_write;
        logic [11:0] csr_addr;
        logic [31:0] csr_value;
        logic        mem_valid;
        logic        mem_write;
        logic [31:0] mem_addr;
        logic [31:0] mem_wdata;
        mem_size_t   mem_size;
        logic        mem_signed;
        logic [31:0] pc;
        logic        trap;
        logic [3:0]  trap_cause;
    } exec_result_t;

endpackage

/* source/exec_top.sv */
module exec_top #(
    parameter int REG_COUNT = 32
) (
    input  logic                   clock,
    input  logic                   reset,
    input  exec_pkg::exec_req_t    exec_req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output exec_pkg::exec_result_t result,
    output logic                   result_valid,
    input  logic                   result_ready,
    output logic                   jump_valid,
    output logic [31:0]            jump_pc,
    input  logic                   load_done,
    input  logic [4:0]             load_done_rd
);
    import exec_pkg::*;

    logic [31:0] operand_a;
    logic [31:0] operand_b;
    alu_fn_t     fn;
    logic [31:0] alu_result;
    logic        alu_equal;
    logic        alu_less_signed;
    logic        alu_less_unsigned;
    logic        hazard;
    logic        accept_load;

    exec_unit u_exec_unit (
        .clock             (clock),
        .reset             (reset),
        .exec_req          (exec_req),
        .req_valid         (req_valid),
        .req_ready         (req_ready),
        .result            (result),
        .result_valid      (result_valid),
        .result_ready      (result_ready),
        .jump_valid        (jump_valid),
        .jump_pc           (jump_pc),
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .fn                (fn),
        .alu_result        (alu_result),
        .alu_equal         (alu_equal),
        .alu_less_signed   (alu_less_signed),
        .alu_less_unsigned (alu_less_unsigned),
        .hazard            (hazard),
        .accept_load       (accept_load)
    );

    alu u_alu (
        .operand_a         (operand_a),
        .operand_b         (operand_b),
        .fn                (fn),
        .alu_result        (alu_result),
        .alu_equal         (alu_equal),
        .alu_less_signed   (alu_less_signed),
        .alu_less_unsigned (alu_less_unsigned)
    );

    // checks the incoming request before it is taken
    load_scoreboard #(
        .REG_COUNT (REG_COUNT)
    ) u_load_scoreboard (
        .clock        (clock),
        .reset        (reset),
        .accept_load  (accept_load),
        .accept_rd    (exec_req.rd),
        .load_done    (load_done),
        .load_done_rd (load_done_rd),
        .check_rd     (exec_req.rd),
        .check_rs1    (exec_req.rs1),
        .check_rs2    (exec_req.rs2),
        .hazard       (hazard)
    );

endmodule

/* source/exec_unit.sv */
module exec_unit (
    input  logic                   clock,
    input  logic                   reset,
    input  exec_pkg::exec_req_t    exec_req,
    input  logic                   req_valid,
    output logic                   req_ready,
    output exec_pkg::exec_result_t result,
    output logic                   result_valid,
    input  logic                   result_ready,
    output logic                   jump_valid,
    output logic [31:0]            jump_pc,
    output logic [31:0]            operand_a,
    output logic [31:0]            operand_b,
    output exec_pkg::alu_fn_t      fn,
    input  logic [31:0]            alu_result,
    input  logic                   alu_equal,
    input  logic                   alu_less_signed,
    input  logic                   alu_less_unsigned,
    input  logic                   hazard,
    output logic                   accept_load
);
    import exec_pkg::*;

    exec_req_t    req_q;
    exec_result_t result_next;
    logic         pass_one;
    logic         result_fresh;
    logic         busy;
    logic         accept;
    logic         equal_q;
    logic         less_signed_q;
    logic         less_unsigned_q;
    logic         branch_taken;
    logic         jump_taken;

    // ----------------------------------------
    // handshake
    // ----------------------------------------

    // a leaving result frees the stage on the same edge
    assign busy        = pass_one | (result_valid & ~result_ready);
    assign req_ready   = ~(busy | hazard);
    assign accept      = req_valid & req_ready;
    assign accept_load = accept & exec_req.op.mem_load & ~exec_req.trap;

    // ----------------------------------------
    // operand select, both passes
    // ----------------------------------------

    always_comb begin
        if (pass_one) begin
            fn = req_q.op.alu_fn;
            case (req_q.op.src_sel)
                src_rs1_rs2: begin
                    operand_a = req_q.rs1_value;
                    operand_b = req_q.rs2_value;
                end
                src_rs1_imm: begin
                    operand_a = req_q.rs1_value;
                    operand_b = req_q.imm;
                end
                src_pc_imm: begin
                    operand_a = req_q.pc;
                    operand_b = req_q.imm;
                end
                src_pc_four: begin
                    operand_a = req_q.pc;
                    operand_b = 32'd4;
                end
                src_rs1_csr: begin
                    operand_a = req_q.rs1_value;
                    operand_b = req_q.csr_value;
                end
                default: begin
                    operand_a = req_q.imm;
                    operand_b = 32'd0;
                end
            endcase
        end else begin
            // second pass, jump target
            fn        = alu_add;
            operand_a = (req_q.op.flow == flow_jalr) ? req_q.rs1_value : req_q.pc;
            operand_b = req_q.imm;
        end
    end

    // ----------------------------------------
    // result packet
    // ----------------------------------------

    always_comb begin
        result_next.gpr_write  = req_q.op.gpr_write & ~req_q.trap;
        result_next.rd         = req_q.rd;
        // csr ops hand the old value back to rd
        result_next.rd_value   = req_q.op.csr_write ? req_q.csr_value : alu_result;
        result_next.csr_write  = req_q.op.csr_write | req_q.trap;
        result_next.csr_addr   = req_q.trap ? csr_mepc : req_q.csr_addr;
        result_next.csr_value  = req_q.trap ? req_q.pc : alu_result;
        result_next.mem_valid  = (req_q.op.mem_load | req_q.op.mem_store) & ~req_q.trap;
        result_next.mem_write  = req_q.op.mem_store;
        result_next.mem_addr   = alu_result;
        result_next.mem_wdata  = req_q.rs2_value;
        result_next.mem_size   = req_q.op.mem_size;
        result_next.mem_signed = req_q.op.mem_signed;
        result_next.pc         = req_q.pc;
        result_next.trap       = req_q.trap;
        result_next.trap_cause = req_q.trap_cause;
    end

    // ----------------------------------------
    // branch decision and jump
    // ----------------------------------------

    always_comb begin
        case (req_q.op.branch_cond)
            cond_eq:  branch_taken = equal_q;
            cond_ne:  branch_taken = ~equal_q;
            cond_lt:  branch_taken = less_signed_q;
            cond_ge:  branch_taken = ~less_signed_q;
            cond_ltu: branch_taken = less_unsigned_q;
            cond_geu: branch_taken = ~less_unsigned_q;
            default:  branch_taken = 1'b0;
        endcase
    end

    assign jump_taken = ~req_q.trap & ((req_q.op.flow == flow_jal)
                                    | (req_q.op.flow == flow_jalr)
                                    | ((req_q.op.flow == flow_branch) & branch_taken));

    // only the first result cycle offers a target
    assign jump_valid = result_fresh & jump_taken;
    assign jump_pc    = (req_q.op.flow == flow_jalr) ? {alu_result[31:1], 1'b0} : alu_result;

    // ----------------------------------------
    // registers
    // ----------------------------------------

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= exec_req;
        end
        if (pass_one) begin
            result          <= result_next;
            equal_q         <= alu_equal;
            less_signed_q   <= alu_less_signed;
            less_unsigned_q <= alu_less_unsigned;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pass_one     <= 1'b0;
            result_fresh <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            pass_one     <= accept;
            result_fresh <= pass_one;
            if (pass_one) begin
                result_valid <= 1'b1;
            end else if (result_ready) begin
                result_valid <= 1'b0;
            end
        end
    end

    result_held: assert property (@(posedge clock) disable iff (reset)
        result_valid && !result_ready |=> result_valid && $stable(result));

    jump_single_pulse: assert property (@(posedge clock) disable iff (reset)
        jump_valid |=> !jump_valid);

endmodule

/* source/load_scoreboard.sv */
module load_scoreboard #(
    parameter int REG_COUNT = 32
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       accept_load,
    input  logic [4:0] accept_rd,
    input  logic       load_done,
    input  logic [4:0] load_done_rd,
    input  logic [4:0] check_rd,
    input  logic [4:0] check_rs1,
    input  logic [4:0] check_rs2,
    output logic       hazard
);
    localparam int INDEX_WIDTH = $clog2(REG_COUNT);

    logic [REG_COUNT-1:0]   pending;
    logic [REG_COUNT-1:0]   pending_next;
    logic [INDEX_WIDTH-1:0] set_index;
    logic [INDEX_WIDTH-1:0] clear_index;
    logic [INDEX_WIDTH-1:0] rd_index;
    logic [INDEX_WIDTH-1:0] rs1_index;
    logic [INDEX_WIDTH-1:0] rs2_index;

    // indices wrap at the register count
    assign set_index   = accept_rd[INDEX_WIDTH-1:0];
    assign clear_index = load_done_rd[INDEX_WIDTH-1:0];
    assign rd_index    = check_rd[INDEX_WIDTH-1:0];
    assign rs1_index   = check_rs1[INDEX_WIDTH-1:0];
    assign rs2_index   = check_rs2[INDEX_WIDTH-1:0];

    assign hazard = pending[rd_index] | pending[rs1_index] | pending[rs2_index];

    always_comb begin
        pending_next = pending;
        if (load_done) begin
            pending_next[clear_index] = 1'b0;
        end
        // set after clear so a new load wins the same edge
        if (accept_load && set_index != '0) begin
            pending_next[set_index] = 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= '0;
        end else begin
            pending <= pending_next;
        end
    end

    // a completed load must match one that was issued earlier
    load_done_was_pending: assert property (@(posedge clock) disable iff (reset)
        load_done && clear_index != '0 |-> pending[clear_index]);

endmodule
